//--- Makefile
# Verilator simulation of the instruction fetch unit

.PHONY: run clean

run: obj_dir/Vtb_ifu
	@out="$$(./obj_dir/Vtb_ifu)"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_ifu: all.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module tb_ifu

clean:
	rm -rf obj_dir

//--- all.f
+incdir+rtl
rtl/ifu_pkg.sv
rtl/icache.sv
rtl/ifu.sv
rtl/fetch_buf.sv
rtl/ifu_top.sv
tests/tb_ifu_assert.sv
tests/tb_ifu.sv

//--- rtl/fetch_buf.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module fetch_buf (
   input  logic                              clk,
   input  logic                              rst_n_i,
   input  logic                              flush_i,
   input  logic [`IFU_FETCH_W-1:0]           win_valid_i,
   input  ifu_pkg::insn_t [`IFU_FETCH_W-1:0] win_insn_i,
   input  ifu_pkg::addr_t                    win_pc_i,     // Window base
   input  logic                              credit_i,
   output logic                              stall_o,
   output logic                              insn_valid_o,
   output ifu_pkg::insn_t                    insn_o,
   output ifu_pkg::addr_t                    insn_pc_o
);
   import ifu_pkg::*;

   localparam int PTR_W = $clog2(`IFU_FBUF_DEPTH);
   localparam int CNT_W = $clog2(`IFU_FBUF_DEPTH + 1);
   localparam int CRD_W = $clog2(`IFU_CREDITS + 1);

   fetch_entry_t     buf_q [`IFU_FBUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [PTR_W-1:0] slot_ptr [`IFU_FETCH_W];   // Queue position per window slot
   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] wr_cnt;
   logic [CRD_W-1:0] credit_q;                  // Free decode slots
   logic             issue;

   // Pack valid slots in order
   always_comb begin
      wr_cnt = '0;
      for (int i = 0; i < `IFU_FETCH_W; i++) begin
         slot_ptr[i] = wr_ptr_q + PTR_W'(wr_cnt);
         if (win_valid_i[i])
            wr_cnt = wr_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `IFU_FETCH_W; i++) begin
         if (win_valid_i[i] && !flush_i) begin
            buf_q[slot_ptr[i]].pc   <= win_pc_i + addr_t'(4 * i);
            buf_q[slot_ptr[i]].insn <= win_insn_i[i];
         end
      end
   end

   // Room for a full window is required before ifu may advance
   assign stall_o      = (cnt_q > CNT_W'(`IFU_FBUF_DEPTH - `IFU_FETCH_W));
   assign insn_valid_o = !flush_i && (cnt_q != '0) && (credit_q != '0);
   assign issue        = insn_valid_o;
   assign insn_o       = buf_q[rd_ptr_q].insn;
   assign insn_pc_o    = buf_q[rd_ptr_q].pc;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
         credit_q <= CRD_W'(`IFU_CREDITS);
      end else begin
         credit_q <= credit_q - CRD_W'(issue) + CRD_W'(credit_i); // Survives flush
         if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
         end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(wr_cnt);
            rd_ptr_q <= rd_ptr_q + PTR_W'(issue);
            cnt_q    <= cnt_q + wr_cnt - CNT_W'(issue);
         end
      end
   end

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module icache (
   input  logic                                      clk,
   input  logic                                      rst_n_i,
   input  logic [`IFU_IC_OFF_W+`IFU_IC_IDX_W-1:0]    idx_addr_i,  // Stage 1 page offset
   input  logic [`IFU_IC_TAG_W-1:0]                  tag_s2_i,
   input  logic [`IFU_FETCH_W-1:0]                   mask_s2_i,
   input  logic                                      kill_s2_i,
   input  logic                                      hold_i,      // Fetch buffer nearly full
   // AXI read
   output logic                                      ar_valid_o,
   input  logic                                      ar_ready_i,
   output ifu_pkg::addr_t                            ar_addr_o,
   output logic [7:0]                                ar_len_o,
   input  logic                                      r_valid_i,
   output logic                                      r_ready_o,
   input  logic [`IFU_AXI_DW-1:0]                    r_data_i,
   input  logic                                      r_last_i,
   // To ifu / fetch buffer
   output logic                                      stall_req_o,
   output ifu_pkg::insn_t [`IFU_FETCH_W-1:0]         ins_o,
   output logic [`IFU_FETCH_W-1:0]                   valid_o
);
   import ifu_pkg::*;

   localparam int OFF_W      = `IFU_IC_OFF_W;
   localparam int IDX_W      = `IFU_IC_IDX_W;
   localparam int TAG_W      = `IFU_IC_TAG_W;
   localparam int LINE_BEATS = `IFU_IC_LINE_BYTES * 8 / `IFU_AXI_DW;
   localparam int BEAT_W     = $clog2(LINE_BEATS);

   // Set storage
   logic [`IFU_IC_SETS-1:0] set_vld_q;
   logic [TAG_W-1:0]        tag_q  [`IFU_IC_SETS];
   logic [`IFU_AXI_DW-1:0]  data_q [`IFU_IC_SETS][LINE_BEATS];

   // Stage 1 decode of the page offset
   logic [IDX_W-1:0]  s1_idx;
   logic [BEAT_W-1:0] s1_beat;

   // Stage 2 registers, loaded from the set read
   logic                   rd_vld_q;
   logic [TAG_W-1:0]       rd_tag_q;
   logic [`IFU_AXI_DW-1:0] rd_word_q;
   logic [IDX_W-1:0]       idx_s2_q;

   // Miss tracking
   ic_state_e         state_q, state_d;
   logic [TAG_W-1:0]  miss_tag_q;
   logic [IDX_W-1:0]  miss_idx_q;
   logic [BEAT_W-1:0] beat_q;
   logic              hit;
   logic              miss;

   assign s1_idx  = idx_addr_i[OFF_W +: IDX_W];
   assign s1_beat = idx_addr_i[OFF_W-1 -: BEAT_W]; // Window picks one beat of the line

   // Stage 1: read the set
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= set_vld_q[s1_idx];
      end
   end

   always_ff @(posedge clk) begin
      rd_tag_q  <= tag_q[s1_idx];
      rd_word_q <= data_q[s1_idx][s1_beat];
      idx_s2_q  <= s1_idx;
   end

   // Stage 2: tag compare
   assign hit  = rd_vld_q && (rd_tag_q == tag_s2_i);
   assign miss = (state_q == IC_IDLE) && !kill_s2_i && !hit;

   assign stall_req_o = (state_q != IC_IDLE) || miss;
   assign ins_o       = rd_word_q;                 // Slot 0 in the low half
   assign valid_o     = (state_q == IC_IDLE && hit && !kill_s2_i && !hold_i) ?
                        mask_s2_i : '0;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IC_IDLE:   if (miss) state_d = IC_AR;
         IC_AR:     if (ar_ready_i) state_d = IC_FILL;
         IC_FILL:   if (r_valid_i && r_last_i) state_d = IC_REPLAY;
         IC_REPLAY: state_d = IC_IDLE;   // Array re-read lands next edge
         default:   state_d = IC_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= IC_IDLE;
         beat_q    <= '0;
         set_vld_q <= '0;
      end else begin
         state_q <= state_d;
         if (miss)
            set_vld_q[idx_s2_q] <= 1'b0;          // Line is about to be overwritten
         if (state_q == IC_AR && ar_ready_i)
            beat_q <= '0;
         if (state_q == IC_FILL && r_valid_i) begin
            beat_q <= beat_q + 1'b1;
            if (r_last_i)
               set_vld_q[miss_idx_q] <= 1'b1;
         end
      end
   end

   // Refill target and line contents
   always_ff @(posedge clk) begin
      if (miss) begin
         miss_tag_q <= tag_s2_i;
         miss_idx_q <= idx_s2_q;
      end
      if (state_q == IC_FILL && r_valid_i) begin
         data_q[miss_idx_q][beat_q] <= r_data_i;
         if (r_last_i)
            tag_q[miss_idx_q] <= miss_tag_q;
      end
   end

   // Line-aligned burst, address held until accepted
   assign ar_valid_o = (state_q == IC_AR);
   assign ar_addr_o  = {miss_tag_q, miss_idx_q, {OFF_W{1'b0}}};
   assign ar_len_o   = 8'(LINE_BEATS - 1);
   assign r_ready_o  = (state_q == IC_FILL);

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu (
   input  logic                              clk,
   input  logic                              rst_n_i,
   input  logic                              redirect_i,
   input  ifu_pkg::addr_t                    redirect_pc_i,
   input  logic                              fbuf_stall_i,
   // AXI read
   output logic                              ar_valid_o,
   input  logic                              ar_ready_i,
   output ifu_pkg::addr_t                    ar_addr_o,
   output logic [7:0]                        ar_len_o,
   input  logic                              r_valid_i,
   output logic                              r_ready_o,
   input  logic [`IFU_AXI_DW-1:0]            r_data_i,
   input  logic                              r_last_i,
   // Window towards the fetch buffer
   output logic [`IFU_FETCH_W-1:0]           win_valid_o,
   output ifu_pkg::insn_t [`IFU_FETCH_W-1:0] win_insn_o,
   output ifu_pkg::addr_t                    win_pc_o
);
   import ifu_pkg::*;

   localparam int WIN_W  = $clog2(`IFU_FETCH_W * 4);   // Byte offset inside a window
   localparam int SLOT_W = $clog2(`IFU_FETCH_W);
   localparam int PGO_W  = `IFU_IC_OFF_W + `IFU_IC_IDX_W;

   addr_t                   pc_q;        // Address in stage 2
   addr_t                   pc_nxt;      // Address in stage 1
   addr_t                   fetch_addr;
   logic                    s2_vld_q;    // Stage 2 holds a real window
   logic [`IFU_IC_TAG_W-1:0] tag_s2_q;
   logic [`IFU_FETCH_W-1:0] mask_s1;
   logic [`IFU_FETCH_W-1:0] mask_s2_q;
   logic                    ic_stall_req;
   logic                    kill_s2;

   always_comb begin
      if (redirect_i)
         pc_nxt = redirect_pc_i;                  // Redirect beats any stall
      else if (!s2_vld_q || ic_stall_req || fbuf_stall_i)
         pc_nxt = pc_q;                           // Re-read the same window
      else
         pc_nxt = {pc_q[`IFU_AW-1:WIN_W], {WIN_W{1'b0}}} + addr_t'(`IFU_FETCH_W * 4);
   end

   assign fetch_addr = {pc_nxt[`IFU_AW-1:WIN_W], {WIN_W{1'b0}}}; // Aligned by window

   // Slots before the entry point are dropped
   always_comb begin
      for (int i = 0; i < `IFU_FETCH_W; i++)
         mask_s1[i] = (pc_nxt[2 +: SLOT_W] <= SLOT_W'(i));
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q     <= `IFU_RESET_PC;
         s2_vld_q <= 1'b0;
      end else begin
         pc_q     <= pc_nxt;
         s2_vld_q <= 1'b1;   // First window enters stage 2
      end
   end

   // Stage 2 tag is the registered upper address
   always_ff @(posedge clk) begin
      tag_s2_q  <= fetch_addr[`IFU_AW-1:PGO_W];
      mask_s2_q <= mask_s1;
   end

   assign kill_s2  = redirect_i || !s2_vld_q;
   assign win_pc_o = {pc_q[`IFU_AW-1:WIN_W], {WIN_W{1'b0}}};

   icache u_icache (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .idx_addr_i  (fetch_addr[PGO_W-1:0]),
      .tag_s2_i    (tag_s2_q),
      .mask_s2_i   (mask_s2_q),
      .kill_s2_i   (kill_s2),
      .hold_i      (fbuf_stall_i),
      .ar_valid_o  (ar_valid_o),
      .ar_ready_i  (ar_ready_i),
      .ar_addr_o   (ar_addr_o),
      .ar_len_o    (ar_len_o),
      .r_valid_i   (r_valid_i),
      .r_ready_o   (r_ready_o),
      .r_data_i    (r_data_i),
      .r_last_i    (r_last_i),
      .stall_req_o (ic_stall_req),
      .ins_o       (win_insn_o),
      .valid_o     (win_valid_o)
   );

endmodule

//--- rtl/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// Core widths
`define IFU_AW            32
`define IFU_INSN_W        32
`define IFU_FETCH_W       2            // Instructions per fetch window

// Direct-mapped icache geometry
`define IFU_IC_LINE_BYTES 16
`define IFU_IC_SETS       16
`define IFU_IC_OFF_W      4            // log2 of line bytes
`define IFU_IC_IDX_W      4            // log2 of sets
// Tag sits above the page offset (index + line offset)
`define IFU_IC_TAG_W      (`IFU_AW - `IFU_IC_OFF_W - `IFU_IC_IDX_W)

// AXI read data width, two beats per line
`define IFU_AXI_DW        64

// Fetch buffer and decode credits
`define IFU_FBUF_DEPTH    8
`define IFU_CREDITS       4            // Decode slots held at reset

`define IFU_RESET_PC      32'h0000_1000

`endif

//--- rtl/ifu_pkg.sv
`include "ifu_cfg.svh"

package ifu_pkg;

   // Fetch address, physical equals virtual
   typedef logic [`IFU_AW-1:0] addr_t;

   // One instruction word
   typedef logic [`IFU_INSN_W-1:0] insn_t;

   // Queue entry passed towards decode
   typedef struct packed {
      addr_t pc;   // Address of this instruction
      insn_t insn;
   } fetch_entry_t;

   // Icache miss handling
   typedef enum logic [1:0] {
      IC_IDLE   = 2'd0,  // Lookup, hit path
      IC_AR     = 2'd1,  // Line request on AR
      IC_FILL   = 2'd2,  // Collecting R beats
      IC_REPLAY = 2'd3   // Re-read of the refilled set
   } ic_state_e;

endpackage

//--- rtl/ifu_top.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_top (
   input  logic                   clk,
   input  logic                   rst_n_i,
   // Redirect from the back end
   input  logic                   redirect_i,
   input  ifu_pkg::addr_t         redirect_pc_i,
   // AXI AR
   output logic                   ar_valid_o,
   input  logic                   ar_ready_i,
   output ifu_pkg::addr_t         ar_addr_o,
   output logic [7:0]             ar_len_o,
   // AXI R
   input  logic                   r_valid_i,
   output logic                   r_ready_o,
   input  logic [`IFU_AXI_DW-1:0] r_data_i,
   input  logic                   r_last_i,
   // Decode, credit based
   output logic                   insn_valid_o,
   output ifu_pkg::insn_t         insn_o,
   output ifu_pkg::addr_t         insn_pc_o,
   input  logic                   credit_i
);
   import ifu_pkg::*;

   logic                    fbuf_stall;
   logic [`IFU_FETCH_W-1:0] win_valid;
   insn_t [`IFU_FETCH_W-1:0] win_insn;
   addr_t                   win_pc;

   ifu u_ifu (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .fbuf_stall_i  (fbuf_stall),
      .ar_valid_o    (ar_valid_o),
      .ar_ready_i    (ar_ready_i),
      .ar_addr_o     (ar_addr_o),
      .ar_len_o      (ar_len_o),
      .r_valid_i     (r_valid_i),
      .r_ready_o     (r_ready_o),
      .r_data_i      (r_data_i),
      .r_last_i      (r_last_i),
      .win_valid_o   (win_valid),
      .win_insn_o    (win_insn),
      .win_pc_o      (win_pc)
   );

   fetch_buf u_fbuf (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .flush_i      (redirect_i),   // Redirect empties the queue
      .win_valid_i  (win_valid),
      .win_insn_i   (win_insn),
      .win_pc_i     (win_pc),
      .credit_i     (credit_i),
      .stall_o      (fbuf_stall),
      .insn_valid_o (insn_valid_o),
      .insn_o       (insn_o),
      .insn_pc_o    (insn_pc_o)
   );

endmodule

//--- tests/tb_ifu.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module tb_ifu;
   import ifu_pkg::*;

   localparam int N_SEQ   = 64;
   localparam int N_BACK  = 16;
   localparam int N_ODD   = 32;
   localparam int N_PRESS = 48;
   localparam int N_SLOW  = 64;
   localparam int TIMEOUT_CYCLES = 40 * (N_SEQ + N_BACK + N_ODD + N_PRESS + N_SLOW);
   localparam addr_t REGION_END = `IFU_RESET_PC + 32'h100;   // Lines filled by test 1

   logic                   clk;
   logic                   rst_n_i;
   logic                   redirect_i;
   addr_t                  redirect_pc_i;
   logic                   ar_valid_o;
   logic                   ar_ready_i;
   addr_t                  ar_addr_o;
   logic [7:0]             ar_len_o;
   logic                   r_valid_i;
   logic                   r_ready_o;
   logic [`IFU_AXI_DW-1:0] r_data_i;
   logic                   r_last_i;
   logic                   insn_valid_o;
   insn_t                  insn_o;
   addr_t                  insn_pc_o;
   logic                   credit_i;

   logic [31:0] rnd = 32'hd162;
   addr_t exp_pc = `IFU_RESET_PC;   // Next pc decode should see
   int    held = 0;                 // Decode slots in use
   int    issued = 0;               // Issues since the last redirect
   int    checks = 0;
   int    errors = 0;
   int    cycle_cnt = 0;
   int    ar_count = 0;
   int    low_ar_count = 0;         // ARs into the test 1 region
   int    redir_seq = 0;            // Bumped by the sequence per redirect
   int    redir_done = 0;
   addr_t redir_target = '0;
   logic  await_first = 1'b0;
   addr_t first_pc = '0;
   logic  slow_mem = 1'b0;
   logic  tight_credits = 1'b0;
   // Memory responder
   logic  busy = 1'b0;
   addr_t burst_addr = '0;
   int    burst_len = 0;
   int    beat_no = 0;

   ifu_top u_ifu_top (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .ar_valid_o    (ar_valid_o),
      .ar_ready_i    (ar_ready_i),
      .ar_addr_o     (ar_addr_o),
      .ar_len_o      (ar_len_o),
      .r_valid_i     (r_valid_i),
      .r_ready_o     (r_ready_o),
      .r_data_i      (r_data_i),
      .r_last_i      (r_last_i),
      .insn_valid_o  (insn_valid_o),
      .insn_o        (insn_o),
      .insn_pc_o     (insn_pc_o),
      .credit_i      (credit_i)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Instruction memory is a hash of the word address
   function automatic insn_t mem_word(input addr_t a);
      addr_t w;
      w = {a[31:2], 2'b00};
      return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]} ^ 32'h0000_0013;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      $display("test %0d %-30s %0d errors", num, name, errors - err_before);
   endtask

   // Redirect, then wait until the new stream has delivered count instructions
   task automatic run_stream(input addr_t target, input int count);
      @(negedge clk);
      redir_target = target;
      redir_seq++;
      wait (redir_done == redir_seq);
      @(negedge clk);
      wait (issued >= count);
      @(negedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Decode consumer, redirect driver and AXI memory, all on one edge
   always @(posedge clk) begin
      if (!rst_n_i) begin
         redirect_i <= 1'b0;
         credit_i   <= 1'b0;
         ar_ready_i <= 1'b0;
         r_valid_i  <= 1'b0;
         r_last_i   <= 1'b0;
      end else begin
         if (insn_valid_o) begin
            if (held >= `IFU_CREDITS) begin
               errors++;
               $display("Error at %0t ns: instruction issued with all %0d decode slots busy",
                        $time, held);
            end
            check_value("insn_pc_o", insn_pc_o, exp_pc);
            check_value("insn_o", insn_o, mem_word(exp_pc));
            if (await_first) begin
               first_pc    = insn_pc_o;
               await_first = 1'b0;
            end
            exp_pc = exp_pc + 4;
            held++;
            issued++;
         end
         if (redir_done != redir_seq) begin
            redirect_i    <= 1'b1;
            redirect_pc_i <= redir_target;
            exp_pc        = redir_target;   // Old stream is dead from here
            issued        = 0;
            await_first   = 1'b1;
            redir_done    = redir_seq;
         end else begin
            redirect_i <= 1'b0;
         end
         rnd = xorshift32(rnd);
         if (held > 0 && (tight_credits ? (rnd[3:0] == 4'd0) : rnd[0])) begin
            credit_i <= 1'b1;               // One freed slot per cycle at most
            held--;
         end else begin
            credit_i <= 1'b0;
         end
         if (ar_valid_o && ar_ready_i) begin
            check_value("ar_len_o", 32'(ar_len_o), 32'd1);
            check_value("ar_addr_o[3:0]", 32'(ar_addr_o[3:0]), 32'd0);
            burst_addr = ar_addr_o;
            burst_len  = int'(ar_len_o);
            beat_no    = 0;
            busy       = 1'b1;
            ar_count++;
            if (ar_addr_o >= `IFU_RESET_PC && ar_addr_o < REGION_END)
               low_ar_count++;
         end
         rnd = xorshift32(rnd);
         ar_ready_i <= slow_mem ? (rnd[2:0] == 3'd0) : (rnd[1:0] != 2'd0);
         if (r_valid_i && r_ready_o) begin
            beat_no++;
            if (r_last_i)
               busy = 1'b0;
         end
         rnd = xorshift32(rnd);
         if (busy && (slow_mem ? (rnd[2:0] == 3'd0) : (rnd[1:0] != 2'd0))) begin
            r_valid_i <= 1'b1;
            r_data_i  <= {mem_word(burst_addr + 8 * beat_no + 4),
                          mem_word(burst_addr + 8 * beat_no)};   // Lower word first
            r_last_i  <= (beat_no == burst_len);
         end else begin
            r_valid_i <= 1'b0;
            r_last_i  <= 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles: decode received too few instructions",
                  cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int err_before;
      int ar_before;
      rst_n_i       = 1'b0;
      redirect_i    = 1'b0;
      redirect_pc_i = '0;
      ar_ready_i    = 1'b0;
      r_valid_i     = 1'b0;
      r_data_i      = '0;
      r_last_i      = 1'b0;
      credit_i      = 1'b0;
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;

      err_before = errors;
      wait (issued >= N_SEQ);
      @(negedge clk);
      report_test(1, "sequential fetch from reset", err_before);

      // Sets 8 to 14 still hold the test 1 lines
      err_before = errors;
      ar_before  = low_ar_count;
      run_stream(`IFU_RESET_PC + 32'h80, N_BACK);
      check_value("AR count in refetched region", low_ar_count, ar_before);
      report_test(2, "redirect into cached region", err_before);

      err_before = errors;
      run_stream(32'h0000_2004, N_ODD);
      check_value("first pc after redirect", first_pc, 32'h0000_2004);
      report_test(3, "redirect to odd word", err_before);

      err_before    = errors;
      tight_credits = 1'b1;
      run_stream(32'h0000_3010, N_PRESS);
      tight_credits = 1'b0;
      report_test(4, "credit back-pressure", err_before);

      err_before = errors;
      slow_mem   = 1'b1;
      run_stream(32'h0000_4000, N_SLOW);
      slow_mem   = 1'b0;
      report_test(5, "slow memory", err_before);

      $display("%0d checks, %0d errors, %0d AR bursts", checks, errors, ar_count);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- tests/tb_ifu_assert.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module tb_ifu_assert (
   input logic                                 clk,
   input logic                                 rst_n_i,
   input logic                                 ar_valid_i,
   input logic                                 ar_ready_i,
   input ifu_pkg::addr_t                       ar_addr_i,
   input logic                                 r_valid_i,
   input logic                                 r_ready_i,
   input logic                                 r_last_i,
   input logic                                 insn_valid_i,
   input logic                                 credit_i,
   input logic [$clog2(`IFU_CREDITS+1)-1:0]    credit_cnt_i,   // Fetch buffer credits
   input ifu_pkg::ic_state_e                   ic_state_i
);
   import ifu_pkg::*;

   localparam int CRD_W = $clog2(`IFU_CREDITS + 1);

   int   in_flight;    // Issued, credit not back yet
   logic burst_open;   // AR taken, last R beat still to come

   // Decode slots and line bursts as seen on the ports
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         in_flight  <= 0;
         burst_open <= 1'b0;
      end else begin
         in_flight <= in_flight + int'(insn_valid_i) - int'(credit_i);
         if (ar_valid_i && ar_ready_i)
            burst_open <= 1'b1;
         else if (r_valid_i && r_ready_i && r_last_i)
            burst_open <= 1'b0;   // Burst done
      end
   end

   // Address must not move until the slave takes it
   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
      else $error("AR address or valid changed before ar_ready");

   // Every decode slot already taken
   a_issue_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
      insn_valid_i |-> (in_flight < `IFU_CREDITS))
      else $error("insn_valid with no decode credit");

   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
      credit_cnt_i <= CRD_W'(`IFU_CREDITS))
      else $error("credit counter above decode slot count");

   // R is only accepted while a line is being filled
   a_r_ready_fill: assert property (@(posedge clk) disable iff (!rst_n_i)
      !burst_open |-> !r_ready_i && (ic_state_i != IC_FILL))
      else $error("r_ready or FILL outside an AR to last-beat burst");

endmodule

bind ifu_top tb_ifu_assert u_ifu_assert (
   .clk          (clk),
   .rst_n_i      (rst_n_i),
   .ar_valid_i   (ar_valid_o),
   .ar_ready_i   (ar_ready_i),
   .ar_addr_i    (ar_addr_o),
   .r_valid_i    (r_valid_i),
   .r_ready_i    (r_ready_o),
   .r_last_i     (r_last_i),
   .insn_valid_i (insn_valid_o),
   .credit_i     (credit_i),
   .credit_cnt_i (u_fbuf.credit_q),
   .ic_state_i   (u_ifu.u_icache.state_q)
);
